// File: design/bus_pkg.sv
package bus_pkg;

  ////////////////////
  // Fetch bus
  ////////////////////

  parameter int unsigned ADDR_W = 32;
  parameter int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  ////////////////////
  // Lockstep bundles
  ////////////////////

  // gnt, rvalid, rdata, err, fetch_enable
  parameter int unsigned IN_BUNDLE_W = DATA_W + 4;

  // instr_req, instr_addr, data_req, data_wdata, core_busy
  parameter int unsigned OUT_BUNDLE_W = ADDR_W + DATA_W + 3;

  // Fetch engine states
  typedef enum logic [1:0] {
    F_IDLE = 2'd0,
    F_REQ  = 2'd1,
    F_WAIT = 2'd2
  } fetch_state_e;

endpackage

// File: design/fetch_core.sv
`timescale 1ns/1ps

module fetch_core import bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  addr_t boot_addr_i,
  input  logic  fetch_enable_i,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  data_t instr_rdata_i,
  input  logic  instr_err_i,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  output logic  data_req_o,
  output data_t data_wdata_o,
  output logic  core_busy_o,
  output logic  alert_major_bus_o
);

  fetch_state_e state_d, state_q;
  addr_t        offset_q;
  data_t        checksum_q;
  logic         data_req_q;
  logic         bus_err_q;
  logic         rsp_seen;

  // Response only counts while a fetch is outstanding
  assign rsp_seen = (state_q == F_WAIT) & instr_rvalid_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      F_IDLE: begin
        if (fetch_enable_i) begin
          state_d = F_REQ;
        end
      end
      // Request held until granted
      F_REQ: begin
        if (instr_gnt_i) begin
          state_d = F_WAIT;
        end
      end
      F_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = fetch_enable_i ? F_REQ : F_IDLE;
        end
      end
      default: state_d = F_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= F_IDLE;
      offset_q   <= '0;
      checksum_q <= '0;
      data_req_q <= 1'b0;
      bus_err_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      data_req_q <= rsp_seen;
      if ((state_q == F_REQ) && instr_gnt_i) begin
        offset_q <= offset_q + addr_t'(4);
      end
      if (rsp_seen) begin
        checksum_q <= checksum_q ^ instr_rdata_i;
        // Sticky until reset
        if (instr_err_i) begin
          bus_err_q <= 1'b1;
        end
      end
    end
  end

  assign instr_req_o       = (state_q == F_REQ);
  assign instr_addr_o      = boot_addr_i + offset_q;
  assign data_req_o        = data_req_q;
  assign data_wdata_o      = checksum_q;
  assign core_busy_o       = (state_q == F_REQ) | (state_q == F_WAIT);
  assign alert_major_bus_o = bus_err_q;

endmodule

// File: design/lockstep_cmp.sv
`timescale 1ns/1ps

module lockstep_cmp import bus_pkg::*; (
  input  logic                    clk_i,
  input  logic                    cmp_en_i,
  input  logic [OUT_BUNDLE_W-1:0] shadow_out_i,
  input  logic [OUT_BUNDLE_W-1:0] main_out_dly_i,
  input  logic                    shadow_bus_alert_i,
  output logic                    alert_major_internal_o,
  output logic                    alert_major_bus_o
);

  logic [OUT_BUNDLE_W-1:0] shadow_out_q;
  logic                    outputs_mismatch;

  ////////////////////
  // Shadow register
  ////////////////////

  // Extra cycle here is why the main outputs are delayed by offset plus one
  always_ff @(posedge clk_i) begin
    shadow_out_q <= shadow_out_i;
  end

  ////////////////////
  // Compare
  ////////////////////

  assign outputs_mismatch = (shadow_out_q != main_out_dly_i);

  // Any differing bit in any field is a major fault
  assign alert_major_internal_o = cmp_en_i & outputs_mismatch;

  // Bus errors seen by the shadow are reported as is
  assign alert_major_bus_o = shadow_bus_alert_i;

endmodule

// File: design/lockstep_delay_line.sv
`timescale 1ns/1ps

module lockstep_delay_line #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Width-1:0] stage_q [Depth];

  // Stage 0 takes the input, the last stage drives the output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[Depth-1];

endmodule

// File: design/lockstep_pkg.sv
package lockstep_pkg;

  ////////////////////
  // Shadow timing
  ////////////////////

  // Cycles the shadow copy runs behind the main core
  parameter int unsigned LOCKSTEP_OFFSET_DEFAULT = 2;

  ////////////////////
  // Reset sequencer
  ////////////////////

  // RST_COUNT    shadow held in reset while the offset is counted
  // RST_RELEASED shadow running, comparison still off
  // CMP_ON       outputs are compared every cycle
  typedef enum logic [1:0] {
    RST_COUNT    = 2'd0,
    RST_RELEASED = 2'd1,
    CMP_ON       = 2'd2
  } rst_seq_e;

endpackage

// File: design/lockstep_rst_seq.sv
`timescale 1ns/1ps

module lockstep_rst_seq import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = LOCKSTEP_OFFSET_DEFAULT
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  // At least one counter bit, also for an offset of one
  localparam int unsigned CntW = (LockstepOffset > 1) ? $clog2(LockstepOffset) : 1;

  rst_seq_e        state_d, state_q;
  logic [CntW-1:0] cnt_q;
  logic            cnt_done;
  logic            shadow_rst_q;

  assign cnt_done = (cnt_q == CntW'(LockstepOffset - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RST_COUNT: begin
        if (cnt_done) begin
          state_d = RST_RELEASED;
        end
      end
      RST_RELEASED: state_d = CMP_ON;
      CMP_ON:       state_d = CMP_ON;
      default:      state_d = RST_COUNT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RST_COUNT;
      cnt_q        <= '0;
      shadow_rst_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == RST_COUNT) && !cnt_done) begin
        cnt_q <= cnt_q + CntW'(1);
      end
      // Shadow reset released on leaving the count state
      if (state_d == RST_RELEASED) begin
        shadow_rst_q <= 1'b1;
      end
    end
  end

  assign shadow_rst_no = shadow_rst_q;
  assign cmp_en_o      = (state_q == CMP_ON);

endmodule

// File: design/lockstep_top.sv
`timescale 1ns/1ps

module lockstep_top import bus_pkg::*, lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = LOCKSTEP_OFFSET_DEFAULT
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  addr_t boot_addr_i,

  // Bus inputs of the main core
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  data_t instr_rdata_i,
  input  logic  instr_err_i,
  input  logic  fetch_enable_i,

  // Outputs of the main core
  input  logic  instr_req_i,
  input  addr_t instr_addr_i,
  input  logic  data_req_i,
  input  data_t data_wdata_i,
  input  logic  core_busy_i,

  output logic  alert_major_internal_o,
  output logic  alert_major_bus_o
);

  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  logic                    shadow_rst_n;
  logic                    cmp_en;
  logic [IN_BUNDLE_W-1:0]  main_in_bundle;
  logic [IN_BUNDLE_W-1:0]  shadow_in_bundle;
  logic [OUT_BUNDLE_W-1:0] main_out_bundle;
  logic [OUT_BUNDLE_W-1:0] main_out_dly;
  logic [OUT_BUNDLE_W-1:0] shadow_out_bundle;

  logic  shadow_instr_gnt;
  logic  shadow_instr_rvalid;
  data_t shadow_instr_rdata;
  logic  shadow_instr_err;
  logic  shadow_fetch_enable;
  logic  shadow_instr_req;
  addr_t shadow_instr_addr;
  logic  shadow_data_req;
  data_t shadow_data_wdata;
  logic  shadow_core_busy;
  logic  shadow_bus_alert;

  lockstep_rst_seq #(
    .LockstepOffset(LockstepOffset)
  ) u_rst_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  ////////////////////
  // Input delay
  ////////////////////

  assign main_in_bundle = {instr_gnt_i, instr_rvalid_i, instr_rdata_i,
                           instr_err_i, fetch_enable_i};

  lockstep_delay_line #(
    .Width(IN_BUNDLE_W),
    .Depth(LockstepOffset)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (main_in_bundle),
    .q_o   (shadow_in_bundle)
  );

  assign {shadow_instr_gnt, shadow_instr_rvalid, shadow_instr_rdata,
          shadow_instr_err, shadow_fetch_enable} = shadow_in_bundle;

  ////////////////////
  // Output delay
  ////////////////////

  // Same field order for main and shadow bundles
  assign main_out_bundle = {instr_req_i, instr_addr_i, data_req_i,
                            data_wdata_i, core_busy_i};

  lockstep_delay_line #(
    .Width(OUT_BUNDLE_W),
    .Depth(OutputsOffset)
  ) u_out_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (main_out_bundle),
    .q_o   (main_out_dly)
  );

  ////////////////////
  // Shadow core
  ////////////////////

  fetch_core u_shadow_core (
    .clk_i            (clk_i),
    .rst_ni           (shadow_rst_n),
    .boot_addr_i      (boot_addr_i),
    .fetch_enable_i   (shadow_fetch_enable),
    .instr_gnt_i      (shadow_instr_gnt),
    .instr_rvalid_i   (shadow_instr_rvalid),
    .instr_rdata_i    (shadow_instr_rdata),
    .instr_err_i      (shadow_instr_err),
    .instr_req_o      (shadow_instr_req),
    .instr_addr_o     (shadow_instr_addr),
    .data_req_o       (shadow_data_req),
    .data_wdata_o     (shadow_data_wdata),
    .core_busy_o      (shadow_core_busy),
    .alert_major_bus_o(shadow_bus_alert)
  );

  assign shadow_out_bundle = {shadow_instr_req, shadow_instr_addr, shadow_data_req,
                              shadow_data_wdata, shadow_core_busy};

  lockstep_cmp u_cmp (
    .clk_i                 (clk_i),
    .cmp_en_i              (cmp_en),
    .shadow_out_i          (shadow_out_bundle),
    .main_out_dly_i        (main_out_dly),
    .shadow_bus_alert_i    (shadow_bus_alert),
    .alert_major_internal_o(alert_major_internal_o),
    .alert_major_bus_o     (alert_major_bus_o)
  );

endmodule

// File: files.f
design/bus_pkg.sv
design/lockstep_pkg.sv
design/fetch_core.sv
design/lockstep_rst_seq.sv
design/lockstep_delay_line.sv
design/lockstep_cmp.sv
design/lockstep_top.sv
verif/tb_clk_gen.sv
verif/tb_lockstep.sv

// File: run.sh
#!/bin/sh
# Build and run the lockstep testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_lockstep \
  -f files.f -o sim_lockstep > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_lockstep > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No pass result found"; exit 1; }
exit 0

// File: verif/lockstep_testdata.txt
# rst boot fe gnt rvalid rdata err | req addr data_req wdata busy | exp_int exp_bus
# One line per cycle, hex fields, main-core columns follow the fetch rule
# Reset, main-core columns hold junk
0 1000 0 0 0 0 0  1 dead 1 ffff 1  0 0
0 1000 0 0 0 0 0  1 dead 1 ffff 1  0 0
0 1000 0 0 0 0 0  0 beef 0 1234 1  0 0
0 1000 0 0 0 0 0  1 0 1 5555 0  0 0
0 1000 0 0 0 0 0  1 dead 1 ffff 1  0 0
0 1000 0 0 0 0 0  0 abcd 1 0 1  0 0
0 1000 0 0 0 0 0  1 dead 0 ffff 1  0 0
0 1000 0 0 0 0 0  1 1 1 1 1  0 0
0 1000 0 0 0 0 0  0 dead 1 ffff 0  0 0
0 1000 0 0 0 0 0  1 dead 1 ffff 1  0 0
# Clean fetches, wdata corrupted on line 6
1 1000 1 0 0 0 0  0 1000 0 0 0  0 0
1 1000 1 1 0 0 0  1 1000 0 0 1  0 0
1 1000 1 0 1 11 0  0 1004 0 0 1  0 0
1 1000 1 1 0 0 0  1 1004 1 11 1  0 0
1 1000 1 0 0 0 0  0 1008 0 11 1  0 0
1 1000 1 0 1 22 0  0 1008 0 11 1  0 0
1 1000 1 1 0 0 0  1 1008 1 34 1  0 0
1 1000 1 0 1 44 0  0 100c 0 33 1  0 0
# Stalled grant, main address runs ahead on line 9
1 1000 1 0 0 0 0  1 100c 1 77 1  0 0
1 1000 1 0 0 0 0  1 1010 0 77 1  1 0
1 1000 1 1 0 0 0  1 100c 0 77 1  0 0
1 1000 1 0 1 8 0  0 1010 0 77 1  0 0
1 1000 1 1 0 0 0  1 1010 1 7f 1  1 0
1 1000 1 0 1 80 0  0 1014 0 7f 1  0 0
1 1000 1 1 0 0 0  1 1014 1 ff 1  0 0
# Bus error with rvalid on line 15
1 1000 1 0 1 100 1  0 1018 0 ff 1  0 0
1 1000 1 1 0 0 0  1 1018 1 1ff 1  0 0
1 1000 0 0 1 2 0  0 101c 0 1ff 1  0 0
1 1000 0 0 0 0 0  0 101c 1 1fd 0  0 1
1 1000 0 0 0 0 0  0 101c 0 1fd 0  0 1
1 1000 0 0 0 0 0  0 101c 0 1fd 0  0 1
1 1000 0 0 0 0 0  0 101c 0 1fd 0  0 1
# Second reset pulse clears the bus alert
0 1000 0 0 0 0 0  1 beef 1 1234 1  0 0
0 1000 0 0 0 0 0  1 beef 1 1234 1  0 0
# Short fetch run, busy corrupted on line 31
1 1000 1 0 0 0 0  0 1000 0 0 0  0 0
1 1000 1 1 0 0 0  1 1000 0 0 1  0 0
1 1000 1 0 1 5a 0  0 1004 0 0 1  0 0
1 1000 1 0 0 0 0  1 1004 1 5a 1  0 0
1 1000 1 1 0 0 0  1 1004 0 5a 1  0 0
1 1000 0 0 1 5a 0  0 1008 0 5a 1  0 0
1 1000 0 0 0 0 0  0 1008 1 0 0  0 0
1 1000 0 0 0 0 0  0 1008 0 0 1  0 0
1 1000 0 0 0 0 0  0 1008 0 0 0  0 0
1 1000 0 0 0 0 0  0 1008 0 0 0  0 0
1 1000 0 0 0 0 0  0 1008 0 0 0  1 0
1 1000 0 0 0 0 0  0 1008 0 0 0  0 0

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: verif/tb_lockstep.sv
`timescale 1ns/1ps

module tb_lockstep import bus_pkg::*; ();

  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned MAX_LINES    = 128;
  localparam string       DATA_FILE    = "verif/lockstep_testdata.txt";

  logic  clk;
  logic  rst_ni;
  addr_t boot_addr;
  logic  instr_gnt;
  logic  instr_rvalid;
  data_t instr_rdata;
  logic  instr_err;
  logic  fetch_enable;
  logic  instr_req;
  addr_t instr_addr;
  logic  data_req;
  data_t data_wdata;
  logic  core_busy;
  logic  alert_major_internal;
  logic  alert_major_bus;

  // One entry per data line
  logic  rst_col   [MAX_LINES];
  addr_t boot_col  [MAX_LINES];
  logic  fe_col    [MAX_LINES];
  logic  gnt_col   [MAX_LINES];
  logic  rvalid_col[MAX_LINES];
  data_t rdata_col [MAX_LINES];
  logic  err_col   [MAX_LINES];
  logic  req_col   [MAX_LINES];
  addr_t addr_col  [MAX_LINES];
  logic  dreq_col  [MAX_LINES];
  data_t wdata_col [MAX_LINES];
  logic  busy_col  [MAX_LINES];
  logic  exp_int   [MAX_LINES];
  logic  exp_bus   [MAX_LINES];

  int num_lines;
  int cycle_cnt;
  int cycle_limit;

  tb_clk_gen #(
    .PeriodNs(100)
  ) u_clk_gen (
    .clk_o(clk)
  );

  lockstep_top uut (
    .clk_i                 (clk),
    .rst_ni                (rst_ni),
    .boot_addr_i           (boot_addr),
    .instr_gnt_i           (instr_gnt),
    .instr_rvalid_i        (instr_rvalid),
    .instr_rdata_i         (instr_rdata),
    .instr_err_i           (instr_err),
    .fetch_enable_i        (fetch_enable),
    .instr_req_i           (instr_req),
    .instr_addr_i          (instr_addr),
    .data_req_i            (data_req),
    .data_wdata_i          (data_wdata),
    .core_busy_i           (core_busy),
    .alert_major_internal_o(alert_major_internal),
    .alert_major_bus_o     (alert_major_bus)
  );

  //////////////////////
  // Helpers
  //////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] v [14];
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the test data file");
    end
    num_lines = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 3 || line.getc(0) == 8'h23) begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                       v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
      if (fields != 14 || num_lines >= MAX_LINES) begin
        stop_with_failure("Malformed or oversized test data file");
      end
      rst_col[num_lines]    = v[0][0];
      boot_col[num_lines]   = v[1];
      fe_col[num_lines]     = v[2][0];
      gnt_col[num_lines]    = v[3][0];
      rvalid_col[num_lines] = v[4][0];
      rdata_col[num_lines]  = v[5];
      err_col[num_lines]    = v[6][0];
      req_col[num_lines]    = v[7][0];
      addr_col[num_lines]   = v[8];
      dreq_col[num_lines]   = v[9][0];
      wdata_col[num_lines]  = v[10];
      busy_col[num_lines]   = v[11][0];
      exp_int[num_lines]    = v[12][0];
      exp_bus[num_lines]    = v[13][0];
      num_lines++;
    end
    $fclose(fd);
  endtask

  task automatic drive_line(input int idx);
    rst_ni       = rst_col[idx];
    boot_addr    = boot_col[idx];
    fetch_enable = fe_col[idx];
    instr_gnt    = gnt_col[idx];
    instr_rvalid = rvalid_col[idx];
    instr_rdata  = rdata_col[idx];
    instr_err    = err_col[idx];
    instr_req    = req_col[idx];
    instr_addr   = addr_col[idx];
    data_req     = dreq_col[idx];
    data_wdata   = wdata_col[idx];
    core_busy    = busy_col[idx];
  endtask

  //////////////////////
  // Timeout
  //////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_with_failure("Timeout: the run took more cycles than the test data allows");
    end
  end

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    void'($urandom(54));
    rst_ni       = 1'b0;
    boot_addr    = '0;
    fetch_enable = 1'b0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    instr_err    = 1'b0;
    instr_req    = 1'b0;
    instr_addr   = '0;
    data_req     = 1'b0;
    data_wdata   = '0;
    core_busy    = 1'b0;
    cycle_cnt    = 0;

    load_testdata();
    cycle_limit = num_lines + RESET_CYCLES + 20;

    // The data opens with the reset cycles
    for (int i = 0; i < RESET_CYCLES; i++) begin
      if (i >= num_lines || rst_col[i] !== 1'b0) begin
        stop_with_failure("Test data does not start with the reset cycles");
      end
    end

    for (int i = 0; i < num_lines; i++) begin
      @(negedge clk);
      drive_line(i);
      #1;
      check_value(alert_major_internal, exp_int[i],
                  $sformatf("line %0d alert_major_internal_o", i));
      check_value(alert_major_bus, exp_bus[i],
                  $sformatf("line %0d alert_major_bus_o", i));
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule
